/* hdl/exu_isa_pkg.sv */
package exu_isa_pkg;

    // execute-stage opcodes, the decoder folds I-type forms onto these
    typedef enum logic [4:0] {
        add,
        sub,
        sll,
        slt,
        sltu,
        xor_op,
        srl,
        sra,
        or_op,
        and_op,
        lui,
        auipc,
        jal,
        jalr,
        beq,
        bne,
        blt,
        bge,
        bltu,
        bgeu,
        load,
        store,
        ebreak
    } exu_op_e;

    typedef enum logic [1:0] {
        size_b,
        size_h,
        size_w
    } exu_size_e;

    typedef struct packed {
        exu_op_e   op;
        exu_size_e size;          // only meaningful for load and store
        logic      load_unsigned; // lbu/lhu
    } exu_uop_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs1_d;
        logic [31:0] rs2_d;
        logic [31:0] imm;
    } exu_operands_t;

    typedef struct packed {
        logic [31:0] rd_d;
        logic [31:0] dnpc;
    } exu_result_t;

endpackage

/* hdl/exu_mem_pkg.sv */
package exu_mem_pkg;

    // data RAM geometry, one entry per 32-bit word
    localparam int dmem_words     = 64;
    localparam int dmem_addr_bits = $clog2(dmem_words);

    // one access on the lsu to dmem link
    typedef struct packed {
        logic                      write;
        logic [dmem_addr_bits-1:0] idx;   // word index, byte address bits 7:2
        logic [31:0]               wdata; // already shifted to its byte lanes
        logic [3:0]                wmask;
    } dmem_req_t;

endpackage

/* hdl/exu_alu.sv */
`timescale 1ns/1ps

module exu_alu import exu_isa_pkg::*; (
    input  exu_uop_t      uop,
    input  exu_operands_t operands,
    output logic [31:0]   res,
    output logic          cmp_true
);

    logic [31:0] var1;
    logic [31:0] var2;

    // operand pair, picked by opcode
    always_comb begin
        unique case (uop.op)
            lui:         {var1, var2} = {operands.imm, 32'd0};
            auipc:       {var1, var2} = {operands.pc, operands.imm};
            jal, jalr:   {var1, var2} = {operands.pc, 32'd4};   // link value
            load, store: {var1, var2} = {operands.rs1_d, operands.imm};
            default:     {var1, var2} = {operands.rs1_d, operands.rs2_d};
        endcase
    end

    always_comb begin
        unique case (uop.op)
            add, lui, auipc, jal, jalr, load, store: res = var1 + var2;
            sub:    res = var1 - var2;
            sll:    res = var1 << var2[4:0];
            slt:    res = {31'd0, $signed(var1) < $signed(var2)};
            sltu:   res = {31'd0, var1 < var2};
            xor_op: res = var1 ^ var2;
            srl:    res = var1 >> var2[4:0];
            sra:    res = $unsigned($signed(var1) >>> var2[4:0]);
            or_op:  res = var1 | var2;
            and_op: res = var1 & var2;
            default: res = 32'd0; // branches and ebreak write no register
        endcase
    end

    // branch condition always compares the two source registers
    always_comb begin
        unique case (uop.op)
            beq:  cmp_true = operands.rs1_d == operands.rs2_d;
            bne:  cmp_true = operands.rs1_d != operands.rs2_d;
            blt:  cmp_true = $signed(operands.rs1_d) < $signed(operands.rs2_d);
            bge:  cmp_true = $signed(operands.rs1_d) >= $signed(operands.rs2_d);
            bltu: cmp_true = operands.rs1_d < operands.rs2_d;
            bgeu: cmp_true = operands.rs1_d >= operands.rs2_d;
            default: cmp_true = 1'b0;
        endcase
    end

endmodule

/* hdl/exu_next_pc.sv */
`timescale 1ns/1ps

module exu_next_pc import exu_isa_pkg::*; (
    input  exu_uop_t      uop,
    input  exu_operands_t operands,
    input  logic          cmp_true,
    output logic [31:0]   dnpc
);

    logic [31:0] ina;
    logic [31:0] inb;
    logic [31:0] sum;

    always_comb begin
        ina = operands.pc;   // sequential pc + 4 unless changed below
        inb = 32'd4;
        unique case (uop.op)
            jal:  inb = operands.imm;
            jalr: begin
                ina = operands.rs1_d;
                inb = operands.imm;
            end
            beq, bne, blt, bge, bltu, bgeu: inb = cmp_true ? operands.imm : 32'd4;
            ebreak: inb = 32'd0;  // stay on the ebreak itself
            default: ;
        endcase
    end

    assign sum  = ina + inb; // the only adder on the pc path
    assign dnpc = (uop.op == jalr) ? {sum[31:1], 1'b0} : sum;

endmodule

/* hdl/exu_lsu.sv */
`timescale 1ns/1ps

module exu_lsu import exu_isa_pkg::*, exu_mem_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        start,
    input  exu_uop_t    uop,
    input  logic [31:0] addr,
    input  logic [31:0] store_data,
    output logic        done,
    output logic [31:0] load_data,
    output logic        mem_req,
    output dmem_req_t   mem_cmd,
    input  logic        mem_ack,
    input  logic [31:0] mem_rdata
);

    typedef enum logic [1:0] {
        lsu_idle,
        lsu_request,
        lsu_release,
        lsu_done
    } lsu_state_e;

    lsu_state_e  state;
    logic [3:0]  wmask;
    logic [31:0] rshift;
    logic [31:0] rext;

    always_comb begin
        unique case (uop.size)
            size_b:  wmask = 4'b0001 << addr[1:0];
            size_h:  wmask = addr[1] ? 4'b1100 : 4'b0011;
            default: wmask = 4'b1111;
        endcase
    end

    // the command only depends on inputs held for the whole operation
    assign mem_cmd.write = (uop.op == store);
    assign mem_cmd.idx   = addr[dmem_addr_bits+1:2];
    assign mem_cmd.wdata = store_data << {addr[1:0], 3'b000};
    assign mem_cmd.wmask = wmask;

    // move the addressed byte lane down to bit 0, then extend
    assign rshift = mem_rdata >> {addr[1:0], 3'b000};

    always_comb begin
        unique case (uop.size)
            size_b:  rext = {{24{rshift[7] & ~uop.load_unsigned}}, rshift[7:0]};
            size_h:  rext = {{16{rshift[15] & ~uop.load_unsigned}}, rshift[15:0]};
            default: rext = rshift;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= lsu_idle;
        end else begin
            unique case (state)
                lsu_idle:    if (start) state <= lsu_request;
                lsu_request: if (mem_ack) state <= lsu_release;  // req drops next cycle
                lsu_release: if (!mem_ack) state <= lsu_done;
                lsu_done:    if (!start) state <= lsu_idle;      // hold done until start falls
                default:     state <= lsu_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == lsu_request && mem_ack)
            load_data <= rext; // rdata is only valid while ack is high
    end

    assign mem_req = (state == lsu_request);
    assign done    = (state == lsu_done);

endmodule

/* hdl/exu_dmem.sv */
`timescale 1ns/1ps

module exu_dmem import exu_mem_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        mem_req,
    input  dmem_req_t   mem_cmd,
    output logic        mem_ack,
    output logic [31:0] mem_rdata
);

    logic [31:0] mem [dmem_words];
    logic        access;

    // one access per handshake, on the edge that raises ack
    assign access = mem_req && !mem_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            mem_ack <= 1'b0;
        else
            mem_ack <= mem_req; // follows req one cycle behind, both ways
    end

    always_ff @(posedge clk) begin
        if (access) begin
            mem_rdata <= mem[mem_cmd.idx]; // old contents on a store
            if (mem_cmd.write) begin
                for (int i = 0; i < 4; i++) begin
                    if (mem_cmd.wmask[i])
                        mem[mem_cmd.idx][8*i +: 8] <= mem_cmd.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

/* hdl/exu_halt_regs.sv */
`timescale 1ns/1ps

module exu_halt_regs (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        halt_set,
    input  logic [31:0] code,
    output logic        halted,
    output logic [31:0] halt_code
);

    // sticky, only reset brings the stage back
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted    <= 1'b0;
            halt_code <= 32'd0;
        end else if (halt_set && !halted) begin
            halted    <= 1'b1;
            halt_code <= code;  // a0 carries the exit code
        end
    end

endmodule

/* hdl/exu_seq.sv */
`timescale 1ns/1ps

module exu_seq import exu_isa_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        op_req,
    input  exu_uop_t    uop,
    input  logic [31:0] pc,
    input  logic [31:0] alu_res,
    input  logic [31:0] dnpc,
    input  logic        halted,
    output logic        lsu_start,
    input  logic        lsu_done,
    input  logic [31:0] load_data,
    output logic        op_ack,
    output exu_result_t op_result,
    output logic        halt_set
);

    typedef enum logic [1:0] {
        seq_idle,
        seq_mem_wait,
        seq_ack,
        seq_release
    } seq_state_e;

    seq_state_e  state;
    logic        accept;
    logic        go_mem;
    logic        finish;
    logic [31:0] rd_next;

    // release behaves like idle so a new request is taken at once
    assign accept = op_req && (state == seq_idle || state == seq_release);
    assign go_mem = accept && !halted && (uop.op == load || uop.op == store);
    assign finish = (accept && !go_mem) || (state == seq_mem_wait && lsu_done);

    always_comb begin
        if (halted) begin
            rd_next = 32'd0;
        end else begin
            unique case (uop.op)
                load: rd_next = load_data;
                store, beq, bne, blt, bge, bltu, bgeu, ebreak: rd_next = 32'd0;
                default: rd_next = alu_res;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= seq_idle;
        end else begin
            unique case (state)
                seq_idle, seq_release: begin
                    if (go_mem)
                        state <= seq_mem_wait;
                    else if (accept)
                        state <= seq_ack;
                    else
                        state <= seq_idle;
                end
                seq_mem_wait: if (lsu_done) state <= seq_ack;
                seq_ack:      if (!op_req) state <= seq_release;
                default:      state <= seq_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (finish)
            op_result <= '{rd_d: rd_next, dnpc: halted ? pc : dnpc};
    end

    assign lsu_start = (state == seq_mem_wait); // falls as soon as we leave mem_wait
    assign op_ack    = (state == seq_ack);
    assign halt_set  = accept && !halted && (uop.op == ebreak); // lands with op_ack

endmodule

/* hdl/exu_top.sv */
`timescale 1ns/1ps

module exu_top import exu_isa_pkg::*, exu_mem_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          op_req,
    input  exu_uop_t      op_uop,
    input  exu_operands_t op_operands,
    output logic          op_ack,
    output exu_result_t   op_result,
    output logic          halted,
    output logic [31:0]   halt_code
);

    logic [31:0] alu_res;
    logic        cmp_true;
    logic [31:0] dnpc;
    logic        lsu_start;
    logic        lsu_done;
    logic [31:0] load_data;
    logic        mem_req;
    dmem_req_t   mem_cmd;
    logic        mem_ack;
    logic [31:0] mem_rdata;
    logic        halt_set;

    exu_alu i_alu (
        .uop      (op_uop),
        .operands (op_operands),
        .res      (alu_res),
        .cmp_true (cmp_true)
    );

    exu_next_pc i_next_pc (
        .uop      (op_uop),
        .operands (op_operands),
        .cmp_true (cmp_true),
        .dnpc     (dnpc)
    );

    exu_lsu i_lsu (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (lsu_start),
        .uop        (op_uop),
        .addr       (alu_res),            // rs1 + imm for load and store
        .store_data (op_operands.rs2_d),
        .done       (lsu_done),
        .load_data  (load_data),
        .mem_req    (mem_req),
        .mem_cmd    (mem_cmd),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

    exu_dmem i_dmem (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    exu_halt_regs i_halt_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .halt_set  (halt_set),
        .code      (op_operands.rs1_d),
        .halted    (halted),
        .halt_code (halt_code)
    );

    exu_seq i_seq (
        .clk       (clk),
        .arst_n    (arst_n),
        .op_req    (op_req),
        .uop       (op_uop),
        .pc        (op_operands.pc),
        .alu_res   (alu_res),
        .dnpc      (dnpc),
        .halted    (halted),
        .lsu_start (lsu_start),
        .lsu_done  (lsu_done),
        .load_data (load_data),
        .op_ack    (op_ack),
        .op_result (op_result),
        .halt_set  (halt_set)
    );

endmodule

/* verification/tb_exu.sv */
`timescale 1ns/1ps

module tb_exu import exu_isa_pkg::*; ();

    logic          clk = 1'b0;
    logic          arst_n;
    logic          op_req;
    exu_uop_t      op_uop;
    exu_operands_t op_operands;
    logic          op_ack;
    exu_result_t   op_result;
    logic          halted;
    logic [31:0]   halt_code;

    typedef struct packed {
        exu_uop_t      uop;
        exu_operands_t operands;
        exu_result_t   exp;
        logic          exp_halted;
        logic [31:0]   exp_code;
        logic          reset_first; // pulse arst_n before this row is sent
    } row_t;

    row_t        rows [96];
    int          n_rows        = 0;
    int          n_resets      = 0;
    logic        reset_pending = 1'b0;
    logic        halt_expect   = 1'b0;
    logic [31:0] code_expect   = 32'h0;
    logic [31:0] lfsr          = 32'd72945;
    logic        table_built   = 1'b0;
    logic        ack_seen      = 1'b0;

    exu_top i_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .op_req      (op_req),
        .op_uop      (op_uop),
        .op_operands (op_operands),
        .op_ack      (op_ack),
        .op_result   (op_result),
        .halted      (halted),
        .halt_code   (halt_code)
    );

    always #20 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else stop_with_error($sformatf("FAILED %s: got 0x%08h, expected 0x%08h",
                                       name, got, exp));
    endtask

    // right-shifting Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_word(output logic [31:0] w);
        w = 32'h0;
        for (int i = 0; i < 32; i++) begin
            w    = {w[30:0], lfsr[0]}; // one step per bit taken
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // register value that the ISA defines for the ALU ops
    function automatic logic [31:0] ref_rd(input exu_op_e op, input exu_operands_t o);
        logic [4:0] shamt;
        shamt = o.rs2_d[4:0];
        case (op)
            add:     return o.rs1_d + o.rs2_d;
            sub:     return o.rs1_d - o.rs2_d;
            sll:     return o.rs1_d << shamt;
            slt:     return ($signed(o.rs1_d) < $signed(o.rs2_d)) ? 32'd1 : 32'd0;
            sltu:    return (o.rs1_d < o.rs2_d) ? 32'd1 : 32'd0;
            xor_op:  return o.rs1_d ^ o.rs2_d;
            srl:     return o.rs1_d >> shamt;
            sra:     return (o.rs1_d >> shamt) | (~(32'hFFFF_FFFF >> shamt) & {32{o.rs1_d[31]}});
            or_op:   return o.rs1_d | o.rs2_d;
            and_op:  return o.rs1_d & o.rs2_d;
            lui:     return o.imm;
            auipc:   return o.pc + o.imm;
            default: return 32'd0;
        endcase
    endfunction

    task automatic add_row(input exu_op_e op, input exu_size_e size, input logic uns,
                           input logic [31:0] pc, input logic [31:0] rs1, input logic [31:0] rs2,
                           input logic [31:0] imm, input logic [31:0] rd,
                           input logic [31:0] dnpc);
        row_t r;
        r.uop         = '{op: op, size: size, load_unsigned: uns};
        r.operands    = '{pc: pc, rs1_d: rs1, rs2_d: rs2, imm: imm};
        r.exp         = '{rd_d: rd, dnpc: dnpc};
        r.exp_halted  = halt_expect;
        r.exp_code    = code_expect;
        r.reset_first = reset_pending;
        rows[n_rows]  = r;
        reset_pending = 1'b0;
        n_rows++;
    endtask

    // loads and stores all sit at pc 0x100
    task automatic mem_row(input exu_op_e op, input exu_size_e size, input logic uns,
                           input logic [31:0] rs1, input logic [31:0] rs2,
                           input logic [31:0] imm, input logic [31:0] rd);
        add_row(op, size, uns, 32'h100, rs1, rs2, imm, rd, 32'h104);
    endtask

    task automatic add_random_row(input exu_op_e op);
        exu_operands_t o;
        logic [31:0]   w;
        draw_word(w);
        o.pc = {w[31:2], 2'b00};
        draw_word(w);
        o.rs1_d = w;
        draw_word(w);
        o.rs2_d = w;
        draw_word(w);
        o.imm = w;
        add_row(op, size_w, 1'b0, o.pc, o.rs1_d, o.rs2_d, o.imm, ref_rd(op, o), o.pc + 32'd4);
    endtask

    task automatic build_table();
        for (int k = 0; k < 24; k++)
            add_random_row(exu_op_e'(k % 12)); // add up to auipc twice over
        add_row(beq,  size_w, 1'b0, 32'h1000, 32'h5, 32'h5, 32'h80, 32'h0, 32'h1080);
        add_row(beq,  size_w, 1'b0, 32'h1000, 32'h5, 32'h6, 32'h80, 32'h0, 32'h1004);
        add_row(bne,  size_w, 1'b0, 32'h1000, 32'h5, 32'h6, 32'hFFFFFFF0, 32'h0, 32'h0FF0);
        add_row(bne,  size_w, 1'b0, 32'h1000, 32'h7, 32'h7, 32'hFFFFFFF0, 32'h0, 32'h1004);
        add_row(blt,  size_w, 1'b0, 32'h1000, 32'hFFFFFFFF, 32'h1, 32'h40, 32'h0, 32'h1040);
        add_row(blt,  size_w, 1'b0, 32'h1000, 32'h1, 32'hFFFFFFFF, 32'h40, 32'h0, 32'h1004);
        add_row(bge,  size_w, 1'b0, 32'h1000, 32'h1, 32'hFFFFFFFF, 32'h20, 32'h0, 32'h1020);
        add_row(bge,  size_w, 1'b0, 32'h1000, 32'hFFFFFFFF, 32'h1, 32'h20, 32'h0, 32'h1004);
        add_row(bge,  size_w, 1'b0, 32'h1000, 32'h3, 32'h3, 32'h20, 32'h0, 32'h1020);
        add_row(bltu, size_w, 1'b0, 32'h1000, 32'h1, 32'hFFFFFFFF, 32'h40, 32'h0, 32'h1040);
        add_row(bltu, size_w, 1'b0, 32'h1000, 32'hFFFFFFFF, 32'h1, 32'h40, 32'h0, 32'h1004);
        add_row(bgeu, size_w, 1'b0, 32'h1000, 32'hFFFFFFFF, 32'h1, 32'h20, 32'h0, 32'h1020);
        add_row(bgeu, size_w, 1'b0, 32'h1000, 32'h1, 32'hFFFFFFFF, 32'h20, 32'h0, 32'h1004);
        add_row(jal,  size_w, 1'b0, 32'h2000, 32'h0, 32'h0, 32'h100, 32'h2004, 32'h2100);
        add_row(jal,  size_w, 1'b0, 32'h2000, 32'h0, 32'h0, 32'hFFFFFF00, 32'h2004, 32'h1F00);
        add_row(jalr, size_w, 1'b0, 32'h3000, 32'h4001, 32'h0, 32'h10, 32'h3004, 32'h4010);
        add_row(jalr, size_w, 1'b0, 32'h3000, 32'h4000, 32'h0, 32'h3, 32'h3004, 32'h4002);
        // build a known word, then patch it byte by byte
        mem_row(store, size_w, 1'b0, 32'h40, 32'h11223344, 32'h0, 32'h0);
        mem_row(store, size_w, 1'b0, 32'h40, 32'h55667788, 32'h4, 32'h0);
        mem_row(store, size_b, 1'b0, 32'h40, 32'h123456AA, 32'h0, 32'h0);
        mem_row(store, size_b, 1'b0, 32'h40, 32'h000000BB, 32'h1, 32'h0);
        mem_row(store, size_b, 1'b0, 32'h50, 32'hFFFFFFCC, 32'hFFFFFFF2, 32'h0);
        mem_row(store, size_b, 1'b0, 32'h40, 32'h000000DD, 32'h3, 32'h0);
        mem_row(load,  size_w, 1'b0, 32'h40, 32'h0, 32'h0, 32'hDDCCBBAA);
        mem_row(store, size_h, 1'b0, 32'h40, 32'hFFFF9876, 32'h4, 32'h0);
        mem_row(load,  size_w, 1'b0, 32'h40, 32'h0, 32'h4, 32'h55669876); // upper half kept
        mem_row(store, size_h, 1'b0, 32'h40, 32'h00001234, 32'h6, 32'h0);
        mem_row(load,  size_b, 1'b0, 32'h40, 32'h0, 32'h0, 32'hFFFFFFAA);
        mem_row(load,  size_b, 1'b1, 32'h40, 32'h0, 32'h1, 32'h000000BB);
        mem_row(load,  size_b, 1'b0, 32'h40, 32'h0, 32'h2, 32'hFFFFFFCC);
        mem_row(load,  size_b, 1'b1, 32'h40, 32'h0, 32'h3, 32'h000000DD);
        mem_row(load,  size_b, 1'b1, 32'h40, 32'h0, 32'h0, 32'h000000AA);
        mem_row(load,  size_b, 1'b0, 32'h40, 32'h0, 32'h3, 32'hFFFFFFDD);
        mem_row(load,  size_h, 1'b0, 32'h40, 32'h0, 32'h4, 32'hFFFF9876);
        mem_row(load,  size_h, 1'b1, 32'h40, 32'h0, 32'h4, 32'h00009876);
        mem_row(load,  size_h, 1'b0, 32'h50, 32'h0, 32'hFFFFFFF6, 32'h00001234);
        mem_row(load,  size_w, 1'b0, 32'h40, 32'h0, 32'h4, 32'h12349876);
        mem_row(load,  size_h, 1'b0, 32'h40, 32'h0, 32'h2, 32'hFFFFDDCC);
        mem_row(load,  size_h, 1'b1, 32'h40, 32'h0, 32'h0, 32'h0000BBAA);
        mem_row(store, size_w, 1'b0, 32'h40, 32'hCAFEF00D, 32'h8, 32'h0);
        mem_row(store, size_b, 1'b0, 32'h40, 32'h0000005A, 32'h9, 32'h0);
        mem_row(load,  size_w, 1'b0, 32'h40, 32'h0, 32'h8, 32'hCAFE5A0D);
        mem_row(load,  size_b, 1'b0, 32'h40, 32'h0, 32'h9, 32'h0000005A);
        // halted from the ebreak on with a0 = 0x2a as the exit code
        halt_expect = 1'b1;
        code_expect = 32'h2A;
        add_row(ebreak, size_w, 1'b0, 32'h200, 32'h2A, 32'h0, 32'h0, 32'h0, 32'h200);
        add_row(add,    size_w, 1'b0, 32'h204, 32'h1, 32'h2, 32'h0, 32'h0, 32'h204);
        add_row(store,  size_w, 1'b0, 32'h208, 32'h40, 32'hDEADBEEF, 32'h0, 32'h0, 32'h208);
        add_row(load,   size_w, 1'b0, 32'h20C, 32'h40, 32'h0, 32'h0, 32'h0, 32'h20C);
        add_row(ebreak, size_w, 1'b0, 32'h210, 32'h77, 32'h0, 32'h0, 32'h0, 32'h210);
        add_row(jal,    size_w, 1'b0, 32'h214, 32'h0, 32'h0, 32'h100, 32'h0, 32'h214);
        // reset clears the halt but not the RAM, so the old word must still be there
        reset_pending = 1'b1;
        n_resets++;
        halt_expect = 1'b0;
        code_expect = 32'h0;
        mem_row(load, size_w, 1'b0, 32'h40, 32'h0, 32'h0, 32'hDDCCBBAA);
        add_row(add,  size_w, 1'b0, 32'h104, 32'h3, 32'h4, 32'h0, 32'h7, 32'h108);
    endtask

    task automatic release_reset();
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        check_value("op_ack", 32'(op_ack), 32'h0);
        check_value("i_dut.mem_req", 32'(i_dut.mem_req), 32'h0);
        check_value("i_dut.mem_ack", 32'(i_dut.mem_ack), 32'h0);
        check_value("halted", 32'(halted), 32'h0);
        check_value("halt_code", halt_code, 32'h0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        arst_n = 1'b0;
        release_reset();
    endtask

    task automatic run_op(input int idx);
        row_t        r;
        exu_result_t held;
        int          waited;
        r = rows[idx];
        @(posedge clk);
        #2;
        op_uop      = r.uop;
        op_operands = r.operands;
        op_req      = 1'b1;
        waited      = 0;
        @(negedge clk);
        while (!op_ack) begin
            if (waited == 30)
                stop_with_error($sformatf("row %0d: op_ack did not rise within 30 cycles", idx));
            waited++;
            @(negedge clk);
        end
        check_value($sformatf("op_result.rd_d (row %0d)", idx), op_result.rd_d, r.exp.rd_d);
        check_value($sformatf("op_result.dnpc (row %0d)", idx), op_result.dnpc, r.exp.dnpc);
        check_value($sformatf("halted (row %0d)", idx), 32'(halted), 32'(r.exp_halted));
        check_value($sformatf("halt_code (row %0d)", idx), halt_code, r.exp_code);
        held = op_result;
        repeat (2) begin // keep op_req up a little longer so the stage has to wait
            @(negedge clk);
            check_value("op_ack", 32'(op_ack), 32'h1);
            check_value("op_result.rd_d", op_result.rd_d, held.rd_d);
            check_value("op_result.dnpc", op_result.dnpc, held.dnpc);
        end
        @(posedge clk);
        #2;
        op_req      = 1'b0;
        op_operands = ~r.operands; // inputs are free now because the result is registered
        waited      = 0;
        @(negedge clk);
        while (op_ack) begin
            if (waited == 1)
                stop_with_error($sformatf("row %0d: op_ack stayed high after op_req fell", idx));
            check_value("op_result.rd_d", op_result.rd_d, held.rd_d);
            check_value("op_result.dnpc", op_result.dnpc, held.dnpc);
            waited++;
            @(negedge clk);
        end
        repeat (2) @(negedge clk); // idle with op_req low so a stray op_ack reaches the monitor
    endtask

    // op_ack may only rise while a request is pending
    always @(negedge clk) begin
        if (op_ack && !ack_seen) begin
            assert (op_req)
            else stop_with_error("op_ack rose while op_req was low");
        end
        ack_seen = op_ack;
    end

    initial begin
        arst_n      = 1'b0;
        op_req      = 1'b0;
        op_uop      = '0;
        op_operands = '0;
        build_table();
        table_built = 1'b1;
        release_reset();
        for (int i = 0; i < n_rows; i++) begin
            if (rows[i].reset_first)
                apply_reset();
            run_op(i);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // 20 cycles per row is far above the slowest load and each reset adds 10 more
    initial begin
        wait (table_built);
        repeat (n_rows * 20 + (n_resets + 1) * 10) @(posedge clk);
        stop_with_error("watchdog expired before all table rows were run");
    end

endmodule

/* exu.f */
hdl/exu_isa_pkg.sv
hdl/exu_mem_pkg.sv
hdl/exu_alu.sv
hdl/exu_next_pc.sv
hdl/exu_lsu.sv
hdl/exu_dmem.sv
hdl/exu_halt_regs.sv
hdl/exu_seq.sv
hdl/exu_top.sv
verification/tb_exu.sv

/* Makefile */
TOP := tb_exu

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f exu.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
